//--- common/arm_pkg.sv
// Shared widths, encodings and stage structs for the three-stage ARM datapath; import into every stage
package arm_pkg;

  localparam int data_w        = 32;
  localparam int reg_addr_w    = 4;
  localparam int num_regs      = 16;
  localparam int shift_field_w = 12;

  // Instruction class field, bits 27:25
  localparam logic [2:0] cls_dp_reg = 3'b000;
  localparam logic [2:0] cls_dp_imm = 3'b001;

  typedef logic [data_w-1:0]     word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;
  typedef logic [31:0]           instr_t;

  // Same order as the opcode field, bits 24:21
  typedef enum logic [3:0] {
    OP_AND, OP_EOR, OP_SUB, OP_RSB,
    OP_ADD, OP_ADC, OP_SBC, OP_RSC,
    OP_TST, OP_TEQ, OP_CMP, OP_CMN,
    OP_ORR, OP_MOV, OP_BIC, OP_MVN
  } alu_op_e;

  typedef enum logic [1:0] {
    LSL, LSR, ASR, ROR
  } shift_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c;  // Set on carry out, or on borrow for subtractions
    logic v;
  } flags_t;

  typedef struct packed {
    alu_op_e                  op;
    logic                     set_flags;  // S bit of a supported instruction
    logic                     write;      // Writes rd at retire
    logic                     imm;        // Rotated immediate operand
    reg_idx_t                 rn;
    reg_idx_t                 rm;
    reg_idx_t                 rd;
    logic [shift_field_w-1:0] shift_field;
  } ctrl_t;

  // ID/EX payload
  typedef struct packed {
    ctrl_t ctrl;
    word_t rn_value;
    word_t rm_value;
  } ex_payload_t;

  // EX/WB payload, also the forwarding source
  typedef struct packed {
    reg_idx_t rd;
    logic     write;
    word_t    result;
  } wb_payload_t;

  typedef struct packed {
    logic     valid;
    logic     write;
    reg_idx_t rd;
    word_t    result;
    flags_t   flags;  // Status after this instruction
  } retire_t;

endpackage

//--- core/arm_core.sv
// Top level of the three-stage data-processing core; drive instr with instr_valid, watch retire
`timescale 1ns/100ps
module arm_core import arm_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    instr_valid,
  input  instr_t  instr,
  output retire_t retire
);

  logic        id_valid;
  instr_t      id_instr;
  ctrl_t       id_ctrl;
  word_t       rn_file, rm_file;
  word_t       rn_value, rm_value;
  ex_payload_t id_payload, ex_payload;
  logic        ex_valid, wb_valid;
  wb_payload_t ex_result, wb_payload;
  flags_t      flags;

  // Input register feeding decode
  always_ff @(posedge clk or posedge reset) begin
    if (reset) id_valid <= 1'b0;
    else       id_valid <= instr_valid;
  end

  always_ff @(posedge clk) begin
    id_instr <= instr;
  end

  decode u_decode (.instr(id_instr), .valid(id_valid), .ctrl(id_ctrl));

  reg_file u_reg_file (
    .clk, .reset,
    .rn(id_ctrl.rn), .rm(id_ctrl.rm),
    .rn_data(rn_file), .rm_data(rm_file),
    .we(wb_valid && wb_payload.write), .wa(wb_payload.rd), .wd(wb_payload.result)
  );

  forward_unit u_forward (
    .rn(id_ctrl.rn), .rm(id_ctrl.rm),
    .rn_file, .rm_file,
    .ex_fwd(ex_result), .wb_fwd(wb_payload),
    .ex_valid, .wb_valid,
    .rn_value, .rm_value
  );

  assign id_payload = '{ctrl: id_ctrl, rn_value: rn_value, rm_value: rm_value};

  pipe_stage #(.payload_t(ex_payload_t)) u_id_ex (
    .clk, .reset,
    .valid_in(id_valid), .data_in(id_payload),
    .valid_out(ex_valid), .data_out(ex_payload)
  );

  execute_unit u_execute (
    .clk, .reset,
    .valid(ex_valid), .ctrl(ex_payload.ctrl),
    .rn_value(ex_payload.rn_value), .rm_value(ex_payload.rm_value),
    .result(ex_result), .flags
  );

  pipe_stage #(.payload_t(wb_payload_t)) u_ex_wb (
    .clk, .reset,
    .valid_in(ex_valid), .data_in(ex_result),
    .valid_out(wb_valid), .data_out(wb_payload)
  );

  // Flags register was loaded on the same edge as EX/WB
  assign retire = '{valid:  wb_valid,
                    write:  wb_valid && wb_payload.write,
                    rd:     wb_payload.rd,
                    result: wb_payload.result,
                    flags:  flags};

endmodule

//--- core/decode.sv
// Decodes a raw data-processing instruction into the control struct used by the later stages
`timescale 1ns/100ps
module decode import arm_pkg::*; (
  input  instr_t instr,
  input  logic   valid,
  output ctrl_t  ctrl
);

  logic dp_imm;
  logic dp_reg;
  logic supported;
  logic compare_only;

  assign dp_imm = (instr[27:25] == cls_dp_imm);
  assign dp_reg = (instr[27:25] == cls_dp_reg) && !instr[4];  // Immediate shift amount only
  assign supported = valid && (dp_imm || dp_reg);

  // TST, TEQ, CMP and CMN share the 10xx opcode pattern
  assign compare_only = (instr[24:23] == 2'b10);

  always_comb begin
    ctrl             = '0;
    ctrl.op          = alu_op_e'(instr[24:21]);
    ctrl.imm         = dp_imm;
    ctrl.rn          = instr[19:16];
    ctrl.rd          = instr[15:12];
    ctrl.rm          = instr[3:0];
    ctrl.shift_field = instr[11:0];
    if (supported) begin
      ctrl.set_flags = instr[20];
      ctrl.write     = !compare_only;
    end
  end

endmodule

//--- core/execute_unit.sv
// Execute stage with the ALU, NZCV generation and the status register; feeds EX/WB and forwarding
`timescale 1ns/100ps
module execute_unit import arm_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        valid,
  input  ctrl_t       ctrl,
  input  word_t       rn_value,
  input  word_t       rm_value,
  output wb_payload_t result,
  output flags_t      flags
);

  word_t       op_b;
  word_t       x, y;
  logic        cin;
  logic        sub;
  logic        arith;
  logic [32:0] arith_sum;
  word_t       res;
  flags_t      next_flags;

  operand_shifter u_shifter (
    .rm_value, .field(ctrl.shift_field), .imm(ctrl.imm), .operand(op_b)
  );

  // Adder inputs; reversed ops swap the operands
  always_comb begin
    x     = rn_value;
    y     = op_b;
    cin   = 1'b0;
    sub   = 1'b1;
    arith = 1'b1;
    case (ctrl.op)
      OP_ADD, OP_CMN: sub = 1'b0;
      OP_ADC: begin
        sub = 1'b0;
        cin = flags.c;
      end
      OP_SUB, OP_CMP: ;
      OP_SBC: cin = flags.c;  // C holds the last borrow
      OP_RSB: begin
        x = op_b;
        y = rn_value;
      end
      OP_RSC: begin
        x   = op_b;
        y   = rn_value;
        cin = flags.c;
      end
      default: arith = 1'b0;
    endcase
  end

  // Bit 32 is carry out for adds and borrow for subtracts
  assign arith_sum = sub ? {1'b0, x} - {1'b0, y} - 33'(cin)
                         : {1'b0, x} + {1'b0, y} + 33'(cin);

  always_comb begin
    case (ctrl.op)
      OP_AND, OP_TST: res = rn_value & op_b;
      OP_EOR, OP_TEQ: res = rn_value ^ op_b;
      OP_ORR:         res = rn_value | op_b;
      OP_MOV:         res = op_b;
      OP_BIC:         res = rn_value & ~op_b;
      OP_MVN:         res = ~op_b;
      default:        res = arith_sum[data_w-1:0];
    endcase
  end

  always_comb begin
    next_flags   = flags;  // Logical ops keep C and V
    next_flags.n = res[data_w-1];
    next_flags.z = (res == '0);
    if (arith) begin
      next_flags.c = arith_sum[data_w];
      next_flags.v = ((x[data_w-1] ^ y[data_w-1]) == sub) && (x[data_w-1] ^ res[data_w-1]);
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)                       flags <= '0;
    else if (valid && ctrl.set_flags) flags <= next_flags;
  end

  assign result = '{rd: ctrl.rd, write: ctrl.write, result: res};

  // Status only moves for a valid instruction with S set
  assert property (@(posedge clk) disable iff (reset)
    !(valid && ctrl.set_flags) |=> $stable(flags));

endmodule

//--- core/forward_unit.sv
// Picks the freshest Rn and Rm values from EX, WB or the register file for the decode stage
`timescale 1ns/100ps
module forward_unit import arm_pkg::*; (
  input  reg_idx_t    rn,
  input  reg_idx_t    rm,
  input  word_t       rn_file,
  input  word_t       rm_file,
  input  wb_payload_t ex_fwd,
  input  wb_payload_t wb_fwd,
  input  logic        ex_valid,
  input  logic        wb_valid,
  output word_t       rn_value,
  output word_t       rm_value
);

  function automatic logic hit(wb_payload_t stage, logic stage_valid, reg_idx_t src);
    return stage_valid && stage.write && (stage.rd == src);
  endfunction

  // EX holds the younger result, so it wins over WB
  function automatic word_t pick(reg_idx_t src, word_t file_value);
    if (hit(ex_fwd, ex_valid, src))      return ex_fwd.result;
    else if (hit(wb_fwd, wb_valid, src)) return wb_fwd.result;
    else                                 return file_value;
  endfunction

  always_comb begin
    rn_value = pick(rn, rn_file);
    rm_value = pick(rm, rm_file);
  end

  // A value other than the file's must come from a stage that writes that register
  always_comb begin
    assert final (rn_value == rn_file || hit(ex_fwd, ex_valid, rn) || hit(wb_fwd, wb_valid, rn));
    assert final (rm_value == rm_file || hit(ex_fwd, ex_valid, rm) || hit(wb_fwd, wb_valid, rm));
  end

endmodule

//--- core/operand_shifter.sv
// Forms the ALU second operand from a rotated immediate or an immediate-shifted Rm
`timescale 1ns/100ps
module operand_shifter import arm_pkg::*; (
  input  word_t                    rm_value,
  input  logic [shift_field_w-1:0] field,
  input  logic                     imm,
  output word_t                    operand
);

  logic [4:0] rot_amt;
  logic [4:0] shift_amt;
  shift_e     kind;

  function automatic word_t ror(word_t value, logic [4:0] amount);
    logic [2*data_w-1:0] dbl;
    dbl = {value, value} >> amount;
    return dbl[data_w-1:0];
  endfunction

  assign rot_amt   = {field[11:8], 1'b0};  // Twice the rotate field
  assign shift_amt = field[11:7];
  assign kind      = shift_e'(field[6:5]);

  // Amount 0 passes Rm through for every kind
  always_comb begin
    if (imm) begin
      operand = ror({24'b0, field[7:0]}, rot_amt);
    end else begin
      case (kind)
        LSL:     operand = rm_value << shift_amt;
        LSR:     operand = rm_value >> shift_amt;
        ASR:     operand = word_t'($signed(rm_value) >>> shift_amt);
        default: operand = ror(rm_value, shift_amt);
      endcase
    end
  end

endmodule

//--- core/reg_file.sv
// Sixteen general registers with two combinational reads and one write from writeback
`timescale 1ns/100ps
module reg_file import arm_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t rn,
  input  reg_idx_t rm,
  output word_t    rn_data,
  output word_t    rm_data,
  input  logic     we,
  input  reg_idx_t wa,
  input  word_t    wd
);

  word_t regs [num_regs];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wa] <= wd;
    end
  end

  // No write-through; WB forwarding covers the write cycle
  assign rn_data = regs[rn];
  assign rm_data = regs[rm];

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_arm_core -f tb.f -o tb_arm_core \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_arm_core > sim.log 2>&1
cat sim.log
! grep -q "Finished with errors" sim.log && grep -q "Finished with no errors" sim.log || exit 1

//--- tb.f
common/arm_pkg.sv
verilog/pipe_stage.sv
core/decode.sv
core/reg_file.sv
core/forward_unit.sv
core/operand_shifter.sv
core/execute_unit.sv
core/arm_core.sv
test/tb_arm_core.sv

//--- test/tb_arm_core.sv
// Directed testbench for arm_core with a register and flag reference model; simulation top module
`timescale 1ns/100ps
module tb_arm_core import arm_pkg::*; ();

  localparam int clk_period   = 4;
  localparam int reset_cycles = 16;
  localparam int num_instr    = 16 + 24 + 28 + 18 + 3;  // Sum over the five tests
  localparam int cycle_limit  = 4 * num_instr + 100;

  logic    clk;
  logic    reset;
  logic    instr_valid;
  instr_t  instr;
  retire_t retire;

  word_t   model_regs [num_regs];
  flags_t  model_flags;
  retire_t expected [$];
  int      errors = 0;
  int      cycles = 0;
  integer  seed = 93;

  arm_core UUT (.clk, .reset, .instr_valid, .instr, .retire);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles with %0d retire records outstanding",
               cycles, expected.size());
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic compare_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  task automatic compare_idx(string name, reg_idx_t got, reg_idx_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  task automatic compare_flags(string name, flags_t got, flags_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  task automatic compare_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("Error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  // Retire checker, sampled away from the drive edge
  always @(negedge clk) begin : retire_monitor
    retire_t exp_rec;
    if (!reset && retire.valid) begin
      if (expected.size() == 0) begin
        errors++;
        $display("Retire record for rd %0d arrived with nothing expected", retire.rd);
      end else begin
        exp_rec = expected.pop_front();
        compare_bit("retire.write", retire.write, exp_rec.write);
        compare_idx("retire.rd", retire.rd, exp_rec.rd);
        if (exp_rec.write) compare_word("retire.result", retire.result, exp_rec.result);
        compare_flags("retire.flags", retire.flags, exp_rec.flags);
      end
    end
  end

  function automatic instr_t imm_instr(alu_op_e op, logic s, reg_idx_t rn, reg_idx_t rd,
                                       logic [3:0] rot, logic [7:0] imm8);
    return {4'hE, cls_dp_imm, op, s, rn, rd, rot, imm8};
  endfunction

  function automatic instr_t reg_instr(alu_op_e op, logic s, reg_idx_t rn, reg_idx_t rd,
                                       logic [4:0] amt, shift_e kind, reg_idx_t rm);
    return {4'hE, cls_dp_reg, op, s, rn, rd, amt, kind, 1'b0, rm};
  endfunction

  // Bit-by-bit rotation and shifting
  function automatic word_t shifted_operand(instr_t ins);
    word_t v;
    int    amt;
    if (ins[25]) begin
      v   = {24'h0, ins[7:0]};
      amt = int'(ins[11:8]) * 2;
      repeat (amt) v = {v[0], v[31:1]};
    end else begin
      v   = model_regs[ins[3:0]];
      amt = int'(ins[11:7]);
      case (ins[6:5])
        2'd0:    v = v << amt;
        2'd1:    v = v >> amt;
        2'd2:    repeat (amt) v = {v[31], v[31:1]};
        default: repeat (amt) v = {v[0], v[31:1]};
      endcase
    end
    return v;
  endfunction

  task automatic add_with_carry(input word_t x, input word_t y, input logic cin,
                                output word_t sum, inout flags_t f);
    logic [32:0] wide;
    wide = {1'b0, x} + {1'b0, y} + {32'h0, cin};
    sum  = wide[31:0];
    f.c  = wide[32];
    f.v  = (x[31] == y[31]) && (sum[31] != x[31]);
  endtask

  task automatic sub_with_borrow(input word_t x, input word_t y, input logic cin,
                                 output word_t diff, inout flags_t f);
    diff = x - y - {31'h0, cin};
    f.c  = ({1'b0, x} < ({1'b0, y} + {32'h0, cin}));  // Borrow
    f.v  = (x[31] != y[31]) && (diff[31] != x[31]);
  endtask

  task automatic predict(instr_t ins);
    retire_t exp_rec;
    alu_op_e op;
    word_t   a;
    word_t   b;
    word_t   res;
    flags_t  f;
    logic    supported;
    op        = alu_op_e'(ins[24:21]);
    supported = (ins[27:25] == 3'b001) || (ins[27:25] == 3'b000 && !ins[4]);
    a         = model_regs[ins[19:16]];
    b         = shifted_operand(ins);
    f         = model_flags;
    case (op)
      OP_ADD, OP_CMN: add_with_carry(a, b, 1'b0, res, f);
      OP_ADC:         add_with_carry(a, b, model_flags.c, res, f);
      OP_SUB, OP_CMP: sub_with_borrow(a, b, 1'b0, res, f);
      OP_SBC:         sub_with_borrow(a, b, model_flags.c, res, f);
      OP_RSB:         sub_with_borrow(b, a, 1'b0, res, f);
      OP_RSC:         sub_with_borrow(b, a, model_flags.c, res, f);
      OP_AND, OP_TST: res = a & b;
      OP_EOR, OP_TEQ: res = a ^ b;
      OP_ORR:         res = a | b;
      OP_MOV:         res = b;
      OP_BIC:         res = a & ~b;
      default:        res = ~b;
    endcase
    f.n = res[31];
    f.z = (res == 32'h0);
    exp_rec.valid  = 1'b1;
    exp_rec.write  = supported && !(op inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN});
    exp_rec.rd     = ins[15:12];
    exp_rec.result = res;
    if (supported && ins[20]) model_flags = f;
    exp_rec.flags = model_flags;
    if (exp_rec.write) model_regs[ins[15:12]] = res;
    expected.push_back(exp_rec);
  endtask

  task automatic issue(instr_t ins);
    instr_valid = 1'b1;
    instr       = ins;
    predict(ins);
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
  endtask

  // Empty slots carry random bits on instr
  task automatic idle(int n);
    repeat (n) begin
      instr = instr_t'($random(seed));
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_drain;
    int n;
    n = 0;
    while (expected.size() != 0 && n < 10) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (expected.size() != 0) begin
      errors += expected.size();
      $display("%0d expected retire records never arrived", expected.size());
      expected.delete();
    end
  endtask

  task automatic load_registers;
    for (int i = 0; i < num_regs; i++) begin
      issue(imm_instr(OP_MOV, 1'b0, 4'd0, reg_idx_t'(i), 4'(i), 8'($random(seed))));
    end
  endtask

  // Gap 0 hits EX, gap 1 hits WB, gap 2 reads the file
  task automatic dependent_chains;
    alu_op_e  ops [4];
    reg_idx_t last;
    reg_idx_t prev;
    reg_idx_t rd;
    ops  = '{OP_ADD, OP_SUB, OP_EOR, OP_ORR};
    last = 4'd1;
    prev = 4'd2;
    for (int gap = 0; gap < 3; gap++) begin
      for (int k = 0; k < 8; k++) begin
        rd = reg_idx_t'(3 * k + gap + 1);
        issue(reg_instr(ops[k % 4], 1'b0, last, rd, 5'd0, LSL, prev));
        prev = last;
        last = rd;
        idle(gap);
      end
    end
  endtask

  task automatic shift_operands;
    logic [4:0] amt;
    for (int kind = 0; kind < 4; kind++) begin
      issue(imm_instr(OP_MVN, 1'b0, 4'd0, 4'd9, 4'd0, 8'($random(seed))));  // Negative r9
      for (int j = 0; j < 6; j++) begin
        if (j == 0) amt = 5'd0;
        else if (j == 1) amt = 5'd31;
        else amt = 5'($random(seed));
        issue(reg_instr(j[0] ? OP_ADD : OP_MOV, 1'b0, reg_idx_t'($random(seed)),
                        reg_idx_t'(10 + j), amt, shift_e'(kind),
                        (j < 3) ? 4'd9 : reg_idx_t'($random(seed))));
      end
    end
  endtask

  task automatic flag_checks;
    issue(imm_instr(OP_MOV, 1'b0, 4'd0, 4'd0, 4'd0, 8'd0));
    issue(imm_instr(OP_MVN, 1'b0, 4'd0, 4'd1, 4'd0, 8'd0));  // 0xffffffff
    issue(imm_instr(OP_MOV, 1'b0, 4'd0, 4'd2, 4'd1, 8'd2));  // 0x80000000
    issue(imm_instr(OP_MVN, 1'b0, 4'd0, 4'd3, 4'd1, 8'd2));  // 0x7fffffff
    issue(imm_instr(OP_MOV, 1'b0, 4'd0, 4'd4, 4'd0, 8'd1));
    issue(reg_instr(OP_ADD, 1'b1, 4'd1, 4'd5, 5'd0, LSL, 4'd4));  // Carry out, zero
    issue(reg_instr(OP_ADC, 1'b1, 4'd0, 4'd6, 5'd0, LSL, 4'd0));
    issue(reg_instr(OP_ADD, 1'b1, 4'd3, 4'd7, 5'd0, LSL, 4'd4));  // Signed overflow
    issue(reg_instr(OP_SUB, 1'b1, 4'd0, 4'd8, 5'd0, LSL, 4'd4));  // Borrow
    issue(reg_instr(OP_SBC, 1'b1, 4'd4, 4'd9, 5'd0, LSL, 4'd0));
    issue(reg_instr(OP_SUB, 1'b1, 4'd2, 4'd10, 5'd0, LSL, 4'd4));
    issue(reg_instr(OP_RSB, 1'b1, 4'd4, 4'd11, 5'd0, LSL, 4'd0));
    issue(reg_instr(OP_RSC, 1'b1, 4'd0, 4'd12, 5'd0, LSL, 4'd4));
    issue(reg_instr(OP_CMP, 1'b1, 4'd4, 4'd0, 5'd0, LSL, 4'd4));
    issue(reg_instr(OP_MOV, 1'b0, 4'd0, 4'd13, 5'd0, LSL, 4'd3));  // Flags carried over
    issue(reg_instr(OP_TST, 1'b1, 4'd1, 4'd0, 5'd0, LSL, 4'd2));
    issue(imm_instr(OP_CMN, 1'b1, 4'd1, 4'd0, 4'd0, 8'd1));
    issue(imm_instr(OP_ORR, 1'b0, 4'd13, 4'd14, 4'd0, 8'd0));
  endtask

  task automatic invalid_and_latency;
    int n;
    idle(4);
    issue(32'hE5912000);  // Load, not a data-processing class
    issue(32'hE0921413);  // Shift by register, S set
    wait_drain;
    issue(imm_instr(OP_ADD, 1'b1, 4'd13, 4'd15, 4'd0, 8'd7));
    n = 1;
    while (!retire.valid && n < 10) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (n != 3) begin
      errors++;
      $display("Retire came %0d cycles after instr_valid instead of 3", n);
    end
    wait_drain;
  endtask

  initial begin
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    model_flags = '0;
    for (int i = 0; i < num_regs; i++) model_regs[i] = '0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
    load_registers;
    dependent_chains;
    shift_operands;
    flag_checks;
    invalid_and_latency;
    wait_drain;
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- verilog/pipe_stage.sv
// Generic pipeline register with a valid bit; instantiate once per stage with its payload type
`timescale 1ns/100ps
module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     valid_in,
  input  payload_t data_in,
  output logic     valid_out,
  output payload_t data_out
);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) valid_out <= 1'b0;
    else       valid_out <= valid_in;
  end

  always_ff @(posedge clk) begin
    data_out <= data_in;  // Qualified by valid_out
  end

  // Upstream is still empty on the first edge after reset drops
  assert property (@(posedge clk) $fell(reset) |=> !valid_out);

endmodule
